//--- Bender.yml
package:
  name: exu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - exu_pkg.sv
      - ex_ls_stage_if.sv
      - exu_bypass.sv
      - exu_alu.sv
      - exu_branch_unit.sv
      - exu_ex_ls_reg.sv
      - exu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - exu_tb.sv

//--- ex_ls_stage_if.sv
// ex/ls stage state
// registered execute result and destination, fed back for forwarding
`timescale 1ns/1ns

interface ex_ls_stage_if (
    input logic clk,
    input logic rst_n
);
    exu_pkg::xlen_t     result;
    exu_pkg::reg_addr_t rd;
    logic               valid;
    logic               dest_wen;
    logic               is_load;

    // driven by the pipeline register
    modport stage (output valid, rd, dest_wen, is_load, result);

    // read by the forwarding logic
    modport fwd (input clk, rst_n, valid, rd, dest_wen, is_load, result);

endinterface

//--- exu.f
+incdir+.
exu_pkg.sv
ex_ls_stage_if.sv
exu_bypass.sv
exu_alu.sv
exu_branch_unit.sv
exu_ex_ls_reg.sv
exu_top.sv
exu_tb.sv

//--- exu_alu.sv
// execute ALU
// add/sub, logic, shifts and set-less-than on the selected operands,
// plus the compare for conditional branches
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_alu (
    input  exu_pkg::alu_op_t    alu_op,
    input  exu_pkg::ctrl_kind_t ctrl_kind,
    input  exu_pkg::xlen_t      op_a,
    input  exu_pkg::xlen_t      op_b,
    output exu_pkg::xlen_t      result,
    output logic                branch_cond
);
    localparam int SHAMT_W = $clog2(`EXU_XLEN);

    logic [SHAMT_W-1:0] shamt;
    exu_pkg::xlen_t     sum;
    exu_pkg::xlen_t     diff;
    logic               lt_signed;
    logic               lt_unsigned;
    logic               equal;

    // ********************
    // shared compare
    // ********************
    assign shamt       = op_b[SHAMT_W-1:0];
    assign sum         = op_a + op_b;
    assign diff        = op_a - op_b;
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;
    assign equal       = (op_a == op_b);

    // ********************
    // result select
    // ********************
    always_comb begin
        case (alu_op)
            exu_pkg::ALU_ADD:  result = sum;
            exu_pkg::ALU_SUB:  result = diff;
            exu_pkg::ALU_AND:  result = op_a & op_b;
            exu_pkg::ALU_OR:   result = op_a | op_b;
            exu_pkg::ALU_XOR:  result = op_a ^ op_b;
            exu_pkg::ALU_SLL:  result = op_a << shamt;
            exu_pkg::ALU_SRL:  result = op_a >> shamt;
            exu_pkg::ALU_SRA:  result = exu_pkg::xlen_t'($signed(op_a) >>> shamt);
            // set results are 0 or 1
            exu_pkg::ALU_SLT:  result = exu_pkg::xlen_t'(lt_signed);
            exu_pkg::ALU_SLTU: result = exu_pkg::xlen_t'(lt_unsigned);
            default:           result = '0;
        endcase
    end

    // ********************
    // branch condition
    // ********************
    always_comb begin
        case (ctrl_kind)
            exu_pkg::CTRL_BEQ:  branch_cond = equal;
            exu_pkg::CTRL_BNE:  branch_cond = !equal;
            exu_pkg::CTRL_BLT:  branch_cond = lt_signed;
            exu_pkg::CTRL_BGE:  branch_cond = !lt_signed;
            exu_pkg::CTRL_BLTU: branch_cond = lt_unsigned;
            exu_pkg::CTRL_BGEU: branch_cond = !lt_unsigned;
            // jumps are always taken
            exu_pkg::CTRL_JAL:  branch_cond = 1'b1;
            exu_pkg::CTRL_JALR: branch_cond = 1'b1;
            default:            branch_cond = 1'b0;
        endcase
    end

endmodule

//--- exu_branch_unit.sv
// branch unit
// forms the jump target and next pc, and gives fetch one jump strobe
// per taken instruction even while it waits in execute
`timescale 1ns/1ns

module exu_branch_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                decode_valid,
    input  logic                decode_ready,
    input  exu_pkg::ctrl_kind_t ctrl_kind,
    input  logic                branch_cond,
    input  exu_pkg::xlen_t      pc,
    input  exu_pkg::xlen_t      seq_pc,
    input  exu_pkg::xlen_t      src1,
    input  exu_pkg::xlen_t      jump_offset,
    output logic                jump_flag,
    output exu_pkg::xlen_t      jump_addr,
    output exu_pkg::xlen_t      next_pc
);
    exu_pkg::xlen_t jump_base;
    exu_pkg::xlen_t target_sum;
    logic           taken;
    logic           accept;
    logic           jump_given;

    assign taken  = (ctrl_kind != exu_pkg::CTRL_NONE) && branch_cond;
    assign accept = decode_valid && decode_ready;

    // jalr jumps off the register, everything else off the pc
    assign jump_base  = (ctrl_kind == exu_pkg::CTRL_JALR) ? src1 : pc;
    assign target_sum = jump_base + jump_offset;
    assign jump_addr  = {target_sum[$bits(exu_pkg::xlen_t)-1:1], 1'b0};
    assign next_pc    = taken ? jump_addr : seq_pc;

    assign jump_flag = decode_valid && taken && !jump_given;

    // remembers that fetch already saw the strobe for the held instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jump_given <= 1'b0;
        end else if (flush || accept) begin
            jump_given <= 1'b0;
        end else if (decode_valid && taken) begin
            jump_given <= 1'b1;
        end
    end

    a_single_jump_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        (jump_flag && !accept && !flush) |=> !jump_flag
    ) else $error("second jump strobe for a stalled instruction");

endmodule

//--- exu_bypass.sv
// operand forwarding
// selects each source from ex/ls, ls/wb or the register file,
// and flags a load-use hazard against the ex/ls slot
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_bypass (
    input  exu_pkg::reg_addr_t rs1,
    input  exu_pkg::reg_addr_t rs2,
    input  exu_pkg::xlen_t     rf_data1,
    input  exu_pkg::xlen_t     rf_data2,
    input  logic               wb_valid,
    input  logic               wb_dest_wen,
    input  exu_pkg::reg_addr_t wb_rd,
    input  exu_pkg::xlen_t     wb_data,
    ex_ls_stage_if.fwd         stage,
    output exu_pkg::xlen_t     src1,
    output exu_pkg::xlen_t     src2,
    output logic               conflict
);
    localparam exu_pkg::reg_addr_t ZERO_REG = exu_pkg::reg_addr_t'(`EXU_ZERO_REG);

    logic ex_fwd_ok;
    logic wb_fwd_ok;
    logic ex_hit1;
    logic ex_hit2;
    logic wb_hit1;
    logic wb_hit2;

    // producers that may forward at all, x0 never does
    assign ex_fwd_ok = stage.valid && stage.dest_wen && (stage.rd != ZERO_REG);
    assign wb_fwd_ok = wb_valid && wb_dest_wen && (wb_rd != ZERO_REG);

    assign ex_hit1 = ex_fwd_ok && (stage.rd == rs1);
    assign ex_hit2 = ex_fwd_ok && (stage.rd == rs2);
    assign wb_hit1 = wb_fwd_ok && (wb_rd == rs1);
    assign wb_hit2 = wb_fwd_ok && (wb_rd == rs2);

    // youngest producer wins
    always_comb begin
        if (ex_hit1) begin
            src1 = stage.result;
        end else if (wb_hit1) begin
            src1 = wb_data;
        end else begin
            src1 = rf_data1;
        end
    end

    always_comb begin
        if (ex_hit2) begin
            src2 = stage.result;
        end else if (wb_hit2) begin
            src2 = wb_data;
        end else begin
            src2 = rf_data2;
        end
    end

    // load data is not there yet, ex/ls only holds the address
    assign conflict = stage.is_load && (ex_hit1 || ex_hit2);

    // a hazard can only come from an occupied ex/ls slot
    a_conflict_needs_valid: assert property (
        @(posedge stage.clk) disable iff (!stage.rst_n) conflict |-> stage.valid
    ) else $error("load-use conflict with an empty ex/ls slot");

endmodule

//--- exu_ex_ls_reg.sv
// ex/ls pipeline register
// decode handshake control and the register toward load/store,
// with back-pressure and flush from downstream
`timescale 1ns/1ns

module exu_ex_ls_reg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               decode_valid,
    input  logic               conflict,
    input  logic               ls_ready,
    output logic               decode_ready,
    input  exu_pkg::xlen_t     result,
    input  exu_pkg::xlen_t     pc,
    input  exu_pkg::xlen_t     next_pc,
    input  exu_pkg::xlen_t     store_data,
    input  exu_pkg::reg_addr_t rd,
    input  logic               dest_wen,
    input  logic               load,
    input  logic               store,
    input  exu_pkg::mem_size_t size,
    ex_ls_stage_if.stage       stage,
    output logic               ex_valid,
    output exu_pkg::xlen_t     ex_result,
    output exu_pkg::xlen_t     ex_pc,
    output exu_pkg::xlen_t     ex_next_pc,
    output exu_pkg::xlen_t     ex_store_data,
    output exu_pkg::reg_addr_t ex_rd,
    output logic               ex_dest_wen,
    output logic               ex_load,
    output logic               ex_store,
    output exu_pkg::mem_size_t ex_size
);
    logic slot_free;

    // ********************
    // stage control
    // ********************

    // slot can take a new entry when empty or being drained
    assign slot_free    = !ex_valid || ls_ready;
    assign decode_ready = decode_valid && slot_free && !conflict && !flush;

    // a stall with a free slot loads a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (slot_free) begin
            ex_valid <= decode_ready;
        end
    end

    // ********************
    // payload
    // ********************
    always_ff @(posedge clk) begin
        if (decode_ready) begin
            ex_result     <= result;
            ex_pc         <= pc;
            ex_next_pc    <= next_pc;
            ex_store_data <= store_data;
            ex_rd         <= rd;
            ex_dest_wen   <= dest_wen;
            ex_load       <= load;
            ex_store      <= store;
            ex_size       <= size;
        end
    end

    // state seen by forwarding
    assign stage.valid    = ex_valid;
    assign stage.rd       = ex_rd;
    assign stage.dest_wen = ex_dest_wen;
    assign stage.is_load  = ex_load;
    assign stage.result   = ex_result;

    a_hold_on_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ex_valid && !ls_ready && !flush) |=>
            ($stable(ex_valid) && $stable(ex_result) && $stable(ex_pc) &&
             $stable(ex_next_pc) && $stable(ex_store_data) && $stable(ex_rd) &&
             $stable(ex_dest_wen) && $stable(ex_load) && $stable(ex_store) &&
             $stable(ex_size))
    ) else $error("ex/ls outputs changed under back-pressure");

endmodule

//--- exu_pkg.sv
// execute stage package
// width types and the ALU and control-transfer operation codes
`include "exu_settings.svh"

package exu_pkg;

    // ********************
    // width types
    // ********************
    typedef logic [`EXU_XLEN-1:0]       xlen_t;
    typedef logic [`EXU_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EXU_SIZE_W-1:0]     mem_size_t;

    // ********************
    // operation codes
    // ********************

    // loads and stores use ALU_ADD for the address
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    // control transfer kind, none for plain ALU work
    typedef enum logic [3:0] {
        CTRL_NONE,
        CTRL_BEQ, CTRL_BNE,
        CTRL_BLT, CTRL_BGE,
        CTRL_BLTU, CTRL_BGEU,
        CTRL_JAL, CTRL_JALR
    } ctrl_kind_t;

endpackage

//--- exu_settings.svh
// execute stage settings
// data and register index widths shared by the execute stage
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// ********************
// data path
// ********************

// integer register width
`define EXU_XLEN 64

// ********************
// register file and memory
// ********************

`define EXU_REG_ADDR_W 5
// x0 reads as zero and is never written
`define EXU_ZERO_REG 0
// size code only passes through to load/store
`define EXU_SIZE_W 2

`endif

//--- exu_tb.sv
// execute stage testbench
// random instruction stream with stalls, flushes and forwarding,
// checked cycle by cycle against a model of the stage
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_tb;

    localparam int NUM_CYCLES = 3000;
    localparam int HOLD_LIMIT = 64;

    logic                clk;
    logic                rst_n;
    logic                decode_valid;
    logic                decode_ready;
    exu_pkg::reg_addr_t  rs1;
    exu_pkg::reg_addr_t  rs2;
    exu_pkg::xlen_t      rf_data1;
    exu_pkg::xlen_t      rf_data2;
    exu_pkg::xlen_t      pc;
    exu_pkg::xlen_t      seq_pc;
    exu_pkg::reg_addr_t  rd;
    logic                dest_wen;
    exu_pkg::alu_op_t    alu_op;
    exu_pkg::ctrl_kind_t ctrl_kind;
    logic                load;
    logic                store;
    exu_pkg::mem_size_t  size;
    exu_pkg::xlen_t      imm_a;
    exu_pkg::xlen_t      imm_b;
    exu_pkg::xlen_t      jump_offset;
    logic                wb_valid;
    exu_pkg::reg_addr_t  wb_rd;
    logic                wb_dest_wen;
    exu_pkg::xlen_t      wb_data;
    logic                ls_ready;
    logic                flush;
    logic                ex_valid;
    exu_pkg::xlen_t      ex_result;
    exu_pkg::xlen_t      ex_pc;
    exu_pkg::xlen_t      ex_next_pc;
    exu_pkg::xlen_t      ex_store_data;
    exu_pkg::reg_addr_t  ex_rd;
    logic                ex_dest_wen;
    logic                ex_load;
    logic                ex_store;
    exu_pkg::mem_size_t  ex_size;
    logic                jump_flag;
    exu_pkg::xlen_t      jump_addr;

    // model copy of the ex/ls slot
    logic               m_valid;
    exu_pkg::xlen_t     m_result;
    exu_pkg::xlen_t     m_pc;
    exu_pkg::xlen_t     m_next_pc;
    exu_pkg::xlen_t     m_store_data;
    exu_pkg::reg_addr_t m_rd;
    logic               m_dest_wen;
    logic               m_load;
    logic               m_store;
    exu_pkg::mem_size_t m_size;
    logic               m_jump_given;

    logic        accepted;
    int          hold_cycles;
    int          accept_count;
    int          errors;
    int          checks;
    logic [31:0] lcg_state;

    exu_top i_dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ********************
    // random numbers
    // ********************
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // use the high bits since the low LCG bits repeat quickly
    function automatic int unsigned pick_below(int unsigned n);
        logic [31:0] r;
        r = next_rand();
        return (r >> 8) % n;
    endfunction

    // small values now and then so compares come out equal
    function automatic exu_pkg::xlen_t rand_word();
        if (pick_below(4) == 0) begin
            return exu_pkg::xlen_t'(pick_below(4));
        end
        return {next_rand(), next_rand()};
    endfunction

    // ********************
    // reference model
    // ********************
    function automatic exu_pkg::xlen_t forward_src(exu_pkg::reg_addr_t rs,
                                                   exu_pkg::xlen_t rf);
        if (rs != `EXU_ZERO_REG && m_valid && m_dest_wen && m_rd == rs) begin
            return m_result;
        end
        if (rs != `EXU_ZERO_REG && wb_valid && wb_dest_wen && wb_rd == rs) begin
            return wb_data;
        end
        return rf;
    endfunction

    function automatic exu_pkg::xlen_t alu_model(exu_pkg::alu_op_t op,
                                                 exu_pkg::xlen_t a, exu_pkg::xlen_t b);
        logic [5:0] sh;
        sh = b[5:0];
        case (op)
            exu_pkg::ALU_ADD:  return a + b;
            exu_pkg::ALU_SUB:  return a - b;
            exu_pkg::ALU_AND:  return a & b;
            exu_pkg::ALU_OR:   return a | b;
            exu_pkg::ALU_XOR:  return a ^ b;
            exu_pkg::ALU_SLL:  return a << sh;
            exu_pkg::ALU_SRL:  return a >> sh;
            exu_pkg::ALU_SRA:  return $signed(a) >>> sh;
            exu_pkg::ALU_SLT:  return {63'd0, $signed(a) < $signed(b)};
            exu_pkg::ALU_SLTU: return {63'd0, a < b};
            default:           return '0;
        endcase
    endfunction

    function automatic logic branch_holds(exu_pkg::ctrl_kind_t kind,
                                          exu_pkg::xlen_t a, exu_pkg::xlen_t b);
        case (kind)
            exu_pkg::CTRL_BEQ:  return a == b;
            exu_pkg::CTRL_BNE:  return a != b;
            exu_pkg::CTRL_BLT:  return $signed(a) < $signed(b);
            exu_pkg::CTRL_BGE:  return $signed(a) >= $signed(b);
            exu_pkg::CTRL_BLTU: return a < b;
            exu_pkg::CTRL_BGEU: return a >= b;
            exu_pkg::CTRL_JAL:  return 1'b1;
            exu_pkg::CTRL_JALR: return 1'b1;
            default:            return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // ********************
    // stimulus
    // ********************
    task automatic new_instruction();
        int unsigned kind;
        kind         = pick_below(8);
        decode_valid = (pick_below(4) != 0);
        // registers 0..3 keep dependences frequent
        rs1          = exu_pkg::reg_addr_t'(pick_below(4));
        rs2          = exu_pkg::reg_addr_t'(pick_below(4));
        rd           = exu_pkg::reg_addr_t'(pick_below(4));
        rf_data1     = rand_word();
        rf_data2     = rand_word();
        pc           = {next_rand(), next_rand()};
        pc[1:0]      = 2'b00;
        seq_pc       = pc + 64'd4;
        imm_a        = rand_word();
        imm_b        = rand_word();
        jump_offset  = rand_word();
        size         = exu_pkg::mem_size_t'(pick_below(4));
        dest_wen     = 1'b1;
        load         = 1'b0;
        store        = 1'b0;
        ctrl_kind    = exu_pkg::CTRL_NONE;
        alu_op       = exu_pkg::alu_op_t'(pick_below(10));
        case (kind)
            4: begin
                load   = 1'b1;
                alu_op = exu_pkg::ALU_ADD;
            end
            5: begin
                store    = 1'b1;
                dest_wen = 1'b0;
                alu_op   = exu_pkg::ALU_ADD;
            end
            6: begin
                ctrl_kind = exu_pkg::ctrl_kind_t'(1 + pick_below(6));
                dest_wen  = 1'b0;
                alu_op    = exu_pkg::ALU_SUB;
            end
            7: begin
                ctrl_kind = pick_below(2) ? exu_pkg::CTRL_JALR : exu_pkg::CTRL_JAL;
                alu_op    = exu_pkg::ALU_ADD;
                // link value is pc plus 4
                imm_a     = pc;
                imm_b     = 64'd4;
                rs2       = '0;
                if (ctrl_kind == exu_pkg::CTRL_JAL) begin
                    rs1 = '0;
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic drive_inputs();
        // decode holds a pending instruction until it is taken
        if (accepted || !decode_valid) begin
            new_instruction();
            hold_cycles = 0;
        end else begin
            hold_cycles++;
        end
        wb_valid    = (pick_below(2) != 0);
        wb_rd       = exu_pkg::reg_addr_t'(pick_below(4));
        wb_dest_wen = (pick_below(4) != 0);
        wb_data     = rand_word();
        ls_ready    = (pick_below(4) != 0);
        flush       = (pick_below(32) == 0);
    endtask

    task automatic check_ex_outputs();
        check_value("ex_valid", ex_valid, m_valid);
        if (m_valid) begin
            check_value("ex_result", ex_result, m_result);
            check_value("ex_pc", ex_pc, m_pc);
            check_value("ex_next_pc", ex_next_pc, m_next_pc);
            check_value("ex_store_data", ex_store_data, m_store_data);
            check_value("ex_rd", ex_rd, m_rd);
            check_value("ex_dest_wen", ex_dest_wen, m_dest_wen);
            check_value("ex_load", ex_load, m_load);
            check_value("ex_store", ex_store, m_store);
            check_value("ex_size", ex_size, m_size);
        end
    endtask

    // combinational checks and the state the next edge should give
    task automatic model_cycle();
        exu_pkg::xlen_t exp_src1;
        exu_pkg::xlen_t exp_src2;
        exu_pkg::xlen_t exp_op_a;
        exu_pkg::xlen_t exp_op_b;
        exu_pkg::xlen_t exp_target;
        exu_pkg::xlen_t exp_next_pc;
        logic           exp_conflict;
        logic           exp_taken;
        logic           slot_free;
        logic           exp_ready;
        exp_src1     = forward_src(rs1, rf_data1);
        exp_src2     = forward_src(rs2, rf_data2);
        exp_conflict = m_valid && m_load && m_dest_wen && m_rd != `EXU_ZERO_REG &&
                       (m_rd == rs1 || m_rd == rs2);
        exp_op_a     = (rs1 != 0 && ctrl_kind != exu_pkg::CTRL_JALR) ? exp_src1 : imm_a;
        exp_op_b     = (rs2 != 0 && !store) ? exp_src2 : imm_b;
        exp_taken    = branch_holds(ctrl_kind, exp_op_a, exp_op_b);
        exp_target   = ((ctrl_kind == exu_pkg::CTRL_JALR) ? exp_src1 : pc) + jump_offset;
        exp_target[0] = 1'b0;
        exp_next_pc  = exp_taken ? exp_target : seq_pc;
        slot_free    = !m_valid || ls_ready;
        exp_ready    = decode_valid && slot_free && !exp_conflict && !flush;
        check_value("decode_ready", decode_ready, exp_ready);
        check_value("jump_flag", jump_flag, decode_valid && exp_taken && !m_jump_given);
        check_value("jump_addr", jump_addr, exp_target);
        accepted = exp_ready;
        if (flush) begin
            m_valid = 1'b0;
        end else if (slot_free) begin
            m_valid = exp_ready;
        end
        if (exp_ready) begin
            accept_count++;
            m_result     = alu_model(alu_op, exp_op_a, exp_op_b);
            m_pc         = pc;
            m_next_pc    = exp_next_pc;
            m_store_data = exp_src2;
            m_rd         = rd;
            m_dest_wen   = dest_wen;
            m_load       = load;
            m_store      = store;
            m_size       = size;
        end
        if (flush || accepted) begin
            m_jump_given = 1'b0;
        end else if (decode_valid && exp_taken) begin
            m_jump_given = 1'b1;
        end
    endtask

    // ********************
    // main sequence
    // ********************
    initial begin
        lcg_state    = 32'h8b73_a19c;
        errors       = 0;
        checks       = 0;
        accept_count = 0;
        hold_cycles  = 0;
        accepted     = 1'b0;
        rst_n        = 1'b0;
        decode_valid = 1'b0;
        rs1          = '0;
        rs2          = '0;
        rf_data1     = '0;
        rf_data2     = '0;
        pc           = '0;
        seq_pc       = '0;
        rd           = '0;
        dest_wen     = 1'b0;
        alu_op       = exu_pkg::ALU_ADD;
        ctrl_kind    = exu_pkg::CTRL_NONE;
        load         = 1'b0;
        store        = 1'b0;
        size         = '0;
        imm_a        = '0;
        imm_b        = '0;
        jump_offset  = '0;
        wb_valid     = 1'b0;
        wb_rd        = '0;
        wb_dest_wen  = 1'b0;
        wb_data      = '0;
        ls_ready     = 1'b1;
        flush        = 1'b0;
        m_valid      = 1'b0;
        m_jump_given = 1'b0;
        m_load       = 1'b0;
        m_dest_wen   = 1'b0;
        m_rd         = '0;
        m_result     = '0;

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        #2;
        rst_n = 1'b1;
        check_value("ex_valid", ex_valid, 1'b0);
        check_value("jump_flag", jump_flag, 1'b0);

        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            #1;
            check_ex_outputs();
            #1;
            drive_inputs();
            if (hold_cycles > HOLD_LIMIT) begin
                errors++;
                $display("timeout: instruction at pc %h not accepted within %0d cycles",
                         pc, HOLD_LIMIT);
                break;
            end
            // sample at the falling edge once inputs have settled
            #8;
            model_cycle();
        end

        $display("accepted %0d checks %0d errors %0d", accept_count, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- exu_top.sv
// execute stage top
// operand selection around forwarding, ALU, branch unit and the
// ex/ls pipeline register
`timescale 1ns/1ns
`include "exu_settings.svh"

module exu_top (
    input  logic                clk,
    input  logic                rst_n,
    // decode side
    input  logic                decode_valid,
    output logic                decode_ready,
    input  exu_pkg::reg_addr_t  rs1,
    input  exu_pkg::reg_addr_t  rs2,
    input  exu_pkg::xlen_t      rf_data1,
    input  exu_pkg::xlen_t      rf_data2,
    input  exu_pkg::xlen_t      pc,
    input  exu_pkg::xlen_t      seq_pc,
    input  exu_pkg::reg_addr_t  rd,
    input  logic                dest_wen,
    input  exu_pkg::alu_op_t    alu_op,
    input  exu_pkg::ctrl_kind_t ctrl_kind,
    input  logic                load,
    input  logic                store,
    input  exu_pkg::mem_size_t  size,
    input  exu_pkg::xlen_t      imm_a,
    input  exu_pkg::xlen_t      imm_b,
    input  exu_pkg::xlen_t      jump_offset,
    // ls/wb side
    input  logic                wb_valid,
    input  exu_pkg::reg_addr_t  wb_rd,
    input  logic                wb_dest_wen,
    input  exu_pkg::xlen_t      wb_data,
    // load/store side
    input  logic                ls_ready,
    input  logic                flush,
    output logic                ex_valid,
    output exu_pkg::xlen_t      ex_result,
    output exu_pkg::xlen_t      ex_pc,
    output exu_pkg::xlen_t      ex_next_pc,
    output exu_pkg::xlen_t      ex_store_data,
    output exu_pkg::reg_addr_t  ex_rd,
    output logic                ex_dest_wen,
    output logic                ex_load,
    output logic                ex_store,
    output exu_pkg::mem_size_t  ex_size,
    // fetch side
    output logic                jump_flag,
    output exu_pkg::xlen_t      jump_addr
);
    localparam exu_pkg::reg_addr_t ZERO_REG = exu_pkg::reg_addr_t'(`EXU_ZERO_REG);

    exu_pkg::xlen_t src1;
    exu_pkg::xlen_t src2;
    exu_pkg::xlen_t op_a;
    exu_pkg::xlen_t op_b;
    exu_pkg::xlen_t alu_result;
    exu_pkg::xlen_t next_pc;
    logic           conflict;
    logic           branch_cond;

    ex_ls_stage_if u_stage_if (.clk(clk), .rst_n(rst_n));

    exu_bypass u_bypass (
        .rs1(rs1), .rs2(rs2), .rf_data1(rf_data1), .rf_data2(rf_data2),
        .wb_valid(wb_valid), .wb_dest_wen(wb_dest_wen), .wb_rd(wb_rd),
        .wb_data(wb_data), .stage(u_stage_if.fwd),
        .src1(src1), .src2(src2), .conflict(conflict)
    );

    // ********************
    // operand select
    // ********************

    // jalr uses src1 only for the target, op_a carries the link base
    assign op_a = ((rs1 != ZERO_REG) && (ctrl_kind != exu_pkg::CTRL_JALR)) ? src1 : imm_a;
    // stores add the offset, src2 goes out as store data
    assign op_b = ((rs2 != ZERO_REG) && !store) ? src2 : imm_b;

    exu_alu u_alu (
        .alu_op(alu_op), .ctrl_kind(ctrl_kind), .op_a(op_a), .op_b(op_b),
        .result(alu_result), .branch_cond(branch_cond)
    );

    exu_branch_unit u_branch (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .decode_valid(decode_valid), .decode_ready(decode_ready),
        .ctrl_kind(ctrl_kind), .branch_cond(branch_cond),
        .pc(pc), .seq_pc(seq_pc), .src1(src1), .jump_offset(jump_offset),
        .jump_flag(jump_flag), .jump_addr(jump_addr), .next_pc(next_pc)
    );

    exu_ex_ls_reg u_ex_ls_reg (
        .clk(clk), .rst_n(rst_n), .flush(flush), .decode_valid(decode_valid),
        .conflict(conflict), .ls_ready(ls_ready), .decode_ready(decode_ready),
        .result(alu_result), .pc(pc), .next_pc(next_pc), .store_data(src2),
        .rd(rd), .dest_wen(dest_wen), .load(load), .store(store), .size(size),
        .stage(u_stage_if.stage),
        .ex_valid(ex_valid), .ex_result(ex_result), .ex_pc(ex_pc),
        .ex_next_pc(ex_next_pc), .ex_store_data(ex_store_data), .ex_rd(ex_rd),
        .ex_dest_wen(ex_dest_wen), .ex_load(ex_load), .ex_store(ex_store),
        .ex_size(ex_size)
    );

endmodule
